//--- Makefile
# Verilator build and run for the pipeline control block

TOP := pipeline_ctrl_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

obj_dir/V$(TOP): pipeline_ctrl_top.f $(wildcard hw/*.sv include/*.svh verification/*.sv)
	verilator --binary --timing --assert -j 0 -f pipeline_ctrl_top.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f pipeline_ctrl_top.f --top-module pipeline_ctrl_top

clean:
	rm -rf obj_dir sim.log

//--- hw/exception_select.sv
/*
 * Exception selector
 * Picks the report that belongs to the oldest in-flight instruction
 */
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_ctrl_consts.svh"

module exception_select
    import pipeline_ctrl_pkg::*;
(
    input  exc_report_t [`PC_NUM_EXC_SOURCES-1:0] exc,
    input  inst_id_t                              oldest_id,
    input  logic [31:0]                           oldest_pc,
    input  logic [`PC_ID_W:0]                     inflight_count,
    output logic                                  exc_pending,
    output logic                                  exc_valid,
    output trap_info_t                            trap
);

    localparam int NSRC  = `PC_NUM_EXC_SOURCES;
    localparam int SEL_W = (NSRC > 1) ? $clog2(NSRC) : 1;

    logic [NSRC-1:0]  src_valid;
    logic [NSRC-1:0]  src_match;
    logic [SEL_W-1:0] sel;

    ////////////////////////////////////////////////////////////////////////////
    // Per-source match

    always_comb begin
        for (int i = 0; i < NSRC; i++) begin
            src_valid[i] = exc[i].valid;
            // Report tagged with the oldest ID
            src_match[i] = exc[i].valid & (exc[i].id == oldest_id);
        end
    end

    // Lowest matching index wins
    always_comb begin
        sel = '0;
        for (int i = NSRC - 1; i >= 0; i--) begin
            if (src_match[i])
                sel = SEL_W'(i);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs to control

    always_comb begin
        exc_pending = |src_valid;
        // An empty pipeline has no oldest instruction
        exc_valid   = (|src_match) & (inflight_count != '0);

        // Chosen source must carry a live report for the oldest ID
        assert (!exc_valid || (exc[sel].valid && (exc[sel].id == oldest_id)))
            else $error("selected exception source does not match the oldest ID");
    end

    // Trap PC comes from the tracker, not the source
    always_comb begin
        trap.pc   = oldest_pc;
        trap.code = exc[sel].code;
        trap.tval = exc[sel].tval;
    end

endmodule

`default_nettype wire

//--- hw/global_control.sv
/*
 * Global pipeline control
 * Reset clear, FENCE.I and MRET drain, interrupts and exception flush
 */
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_ctrl_consts.svh"

module global_control
    import pipeline_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  issue_t            issue,
    input  logic              branch_flush,
    input  logic              exc_pending,
    input  logic              exc_valid,
    input  logic              interrupt_pending,
    input  logic [`PC_ID_W:0] inflight_count,
    input  logic              sq_empty,
    input  logic              stores_pending,
    input  logic [31:0]       trap_vector,
    input  logic [31:0]       epc,
    output gc_ctrl_t          ctrl,
    output logic              squash,
    output logic              exc_ack,
    output logic              mret,
    output logic              interrupt_taken
);

    localparam int CLR_W = $clog2(`PC_INIT_CLEAR_DEPTH) + 1;

    typedef enum logic [2:0] {
        ST_RESET      = 3'd0,
        ST_INIT_CLEAR = 3'd1,
        ST_IDLE       = 3'd2,
        ST_DRAIN      = 3'd3,
        ST_FLUSH      = 3'd4,
        ST_DISCARD    = 3'd5
    } gc_state_t;

    gc_state_t state;
    gc_state_t next_state;

    logic [CLR_W-1:0] clear_count;
    logic             clear_done;
    logic             ctrl_op_issue;
    logic             ifence_in_progress;
    logic             mret_in_progress;
    logic [31:0]      op_pc;
    logic             pipe_quiet;
    logic             flush_next;
    logic             op_pending;

    // Registered controls
    logic        fetch_hold_r;
    logic        issue_hold_r;
    logic        wb_suppress_r;
    logic        retire_hold_r;
    logic        init_clear_r;
    logic        sq_flush_r;
    logic        pc_override_r;
    logic [31:0] pc_r;

    ////////////////////////////////////////////////////////////////////////////
    // Control op tracking

    assign ctrl_op_issue = issue_valid & (issue.op != OP_NORMAL);
    assign flush_next    = (next_state == ST_FLUSH);
    assign op_pending    = ifence_in_progress | mret_in_progress;

    // Cleared on any flush, an exception flush discards the op
    always_ff @(posedge clk) begin
        if (rst) begin
            ifence_in_progress <= 1'b0;
            mret_in_progress   <= 1'b0;
        end else if (flush_next) begin
            ifence_in_progress <= 1'b0;
            mret_in_progress   <= 1'b0;
        end else begin
            ifence_in_progress <= ifence_in_progress |
                                  (issue_valid & (issue.op == OP_IFENCE));
            mret_in_progress   <= mret_in_progress |
                                  (issue_valid & (issue.op == OP_MRET));
        end
    end

    // PC of the last control op
    always_ff @(posedge clk) begin
        if (ctrl_op_issue)
            op_pc <= issue.pc;
    end

    // No older work and no stores left
    assign pipe_quiet = (inflight_count == '0) & sq_empty;

    ////////////////////////////////////////////////////////////////////////////
    // Init clear counter

    always_ff @(posedge clk) begin
        if (rst || state != ST_INIT_CLEAR)
            clear_count <= '0;
        else
            clear_count <= clear_count + 1'b1;
    end

    assign clear_done = (clear_count == CLR_W'(`PC_INIT_CLEAR_DEPTH - 1));

    ////////////////////////////////////////////////////////////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (rst)
            state <= ST_RESET;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET:      next_state = ST_INIT_CLEAR;
            ST_INIT_CLEAR: if (clear_done) next_state = ST_IDLE;
            ST_IDLE: begin
                // Oldest instruction already faulted
                if (exc_valid)
                    next_state = ST_FLUSH;
                else if (ctrl_op_issue | interrupt_pending | exc_pending)
                    next_state = ST_DRAIN;
            end
            ST_DRAIN: begin
                if (exc_valid)
                    next_state = ST_FLUSH;
                else if (pipe_quiet & (op_pending | interrupt_pending))
                    next_state = ST_FLUSH;
                else if (!(op_pending | interrupt_pending | exc_pending))
                    next_state = ST_IDLE;
            end
            // Single redirect cycle
            ST_FLUSH:      next_state = ST_DISCARD;
            ST_DISCARD:    if (!stores_pending) next_state = ST_IDLE;
            default:       next_state = ST_RESET;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobes into flush

    assign exc_ack         = exc_valid & flush_next;
    assign mret            = mret_in_progress & flush_next & ~exc_valid;
    assign interrupt_taken = interrupt_pending & flush_next &
                             ~(op_pending | exc_valid);

    // Realign the tracker for trap flushes
    assign squash = flush_next & (exc_valid | interrupt_taken);

    ////////////////////////////////////////////////////////////////////////////
    // Registered controls

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_hold_r  <= 1'b1;
            issue_hold_r  <= 1'b1;
            wb_suppress_r <= 1'b1;
            retire_hold_r <= 1'b0;
            init_clear_r  <= 1'b0;
            sq_flush_r    <= 1'b0;
            pc_override_r <= 1'b0;
            pc_r          <= '0;
        end else begin
            fetch_hold_r  <= next_state inside {ST_RESET, ST_INIT_CLEAR, ST_DRAIN, ST_FLUSH};
            issue_hold_r  <= next_state inside {ST_RESET, ST_INIT_CLEAR, ST_DRAIN, ST_FLUSH,
                                                ST_DISCARD};
            wb_suppress_r <= next_state inside {ST_RESET, ST_INIT_CLEAR, ST_DISCARD};
            retire_hold_r <= flush_next;
            init_clear_r  <= (next_state == ST_INIT_CLEAR);
            sq_flush_r    <= (state == ST_DISCARD) & (next_state == ST_IDLE);
            pc_override_r <= next_state inside {ST_INIT_CLEAR, ST_FLUSH};
            // Redirect target, trap first
            if (next_state == ST_INIT_CLEAR)
                pc_r <= `PC_RESET_VECTOR;
            else if (exc_valid | interrupt_taken)
                pc_r <= trap_vector;
            else if (ifence_in_progress)
                pc_r <= op_pc + 32'd4;
            else
                pc_r <= epc;
        end
    end

    always_comb begin
        ctrl.fetch_hold         = fetch_hold_r;
        ctrl.issue_hold         = issue_hold_r;
        // Branch flush passes straight through
        ctrl.fetch_flush        = branch_flush | pc_override_r;
        ctrl.writeback_suppress = wb_suppress_r;
        ctrl.retire_hold        = retire_hold_r;
        ctrl.init_clear         = init_clear_r;
        ctrl.sq_flush           = sq_flush_r;
        ctrl.pc_override        = pc_override_r;
        ctrl.pc                 = pc_r;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Assertions

    // Acked exception redirects to the trap vector
    ack_redirects_to_trap: assert property (@(posedge clk) disable iff (rst)
        exc_ack |=> ctrl.pc_override && ctrl.retire_hold &&
                    (ctrl.pc == $past(trap_vector)))
        else $error("exception ack without a trap vector redirect");

    idle_no_override: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> !ctrl.pc_override)
        else $error("pc override while idle");

endmodule

`default_nettype wire

//--- hw/inflight_tracker.sv
/*
 * In-flight instruction tracker
 * Hands out IDs at issue, keeps each PC and reports the oldest entry
 */
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_ctrl_consts.svh"

module inflight_tracker
    import pipeline_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  issue_t            issue,
    input  logic              retire_valid,
    input  logic              squash,
    output inst_id_t          issue_id,
    output inst_id_t          oldest_id,
    output logic [31:0]       oldest_pc,
    output logic [`PC_ID_W:0] inflight_count
);

    localparam int CNT_W   = `PC_ID_W + 1;
    localparam int NUM_IDS = 2 ** `PC_ID_W;

    inst_id_t    next_id;
    inst_id_t    oldest_id_r;
    logic [CNT_W-1:0] count_r;
    logic [31:0] pc_table [NUM_IDS];
    logic        issue_fire;

    ////////////////////////////////////////////////////////////////////////////
    // Issue side

    // Control ops stay out of the table
    assign issue_fire = issue_valid & (issue.op == OP_NORMAL);

    // ID is visible in the issue cycle
    assign issue_id = next_id;

    // PC table, indexed by ID
    always_ff @(posedge clk) begin
        if (issue_fire)
            pc_table[next_id] <= issue.pc;
    end

    ////////////////////////////////////////////////////////////////////////////
    // ID pointers and count

    always_ff @(posedge clk) begin
        if (rst) begin
            next_id     <= '0;
            oldest_id_r <= '0;
            count_r     <= '0;
        end else begin
            next_id <= next_id + inst_id_t'(issue_fire);
            if (squash) begin
                // Everything in flight is dropped, an op issued now too
                oldest_id_r <= next_id + inst_id_t'(issue_fire);
                count_r     <= '0;
            end else begin
                oldest_id_r <= oldest_id_r + inst_id_t'(retire_valid);
                count_r     <= count_r + CNT_W'(issue_fire) - CNT_W'(retire_valid);
            end
        end
    end

    assign oldest_id      = oldest_id_r;
    assign oldest_pc      = pc_table[oldest_id_r];
    assign inflight_count = count_r;

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the surrounding pipeline

    // Retire only with something in flight
    retire_not_empty: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> (count_r != '0))
        else $error("retire with no instruction in flight");

    // Issue held off once all IDs are used
    issue_not_full: assert property (@(posedge clk) disable iff (rst)
        issue_fire |-> (count_r != CNT_W'(NUM_IDS)))
        else $error("issue with all IDs in flight");

endmodule

`default_nettype wire

//--- hw/pipeline_ctrl_pkg.sv
/*
 * Pipeline control types
 * Issue packets, exception reports, trap info and global control outputs
 */
`default_nettype none

`include "pipeline_ctrl_consts.svh"

package pipeline_ctrl_pkg;

    // Kind of instruction seen at issue
    typedef enum logic [1:0] {
        OP_NORMAL = 2'd0,
        OP_IFENCE = 2'd1,
        OP_MRET   = 2'd2
    } ctrl_op_t;

    typedef logic [`PC_ID_W-1:0] inst_id_t;

    // Issue packet from decode
    typedef struct packed {
        ctrl_op_t    op;
        logic [31:0] pc;
    } issue_t;

    // One report per exception source
    typedef struct packed {
        logic        valid;
        logic [3:0]  code;
        inst_id_t    id;
        logic [31:0] tval;
    } exc_report_t;

    // Exception being taken
    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  code;
        logic [31:0] tval;
    } trap_info_t;

    // Global pipeline controls
    typedef struct packed {
        logic        fetch_hold;
        logic        issue_hold;
        logic        fetch_flush;
        logic        writeback_suppress;
        logic        retire_hold;
        logic        init_clear;
        logic        sq_flush;
        logic        pc_override;
        logic [31:0] pc;
    } gc_ctrl_t;

endpackage

`default_nettype wire

//--- hw/pipeline_ctrl_top.sv
/*
 * Pipeline control top level
 * Tracker, exception selector and global control unit
 */
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_ctrl_consts.svh"

module pipeline_ctrl_top
    import pipeline_ctrl_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  issue_valid,
    input  issue_t                                issue,
    input  logic                                  retire_valid,
    input  exc_report_t [`PC_NUM_EXC_SOURCES-1:0] exc,
    input  logic                                  interrupt_pending,
    input  logic [31:0]                           trap_vector,
    input  logic [31:0]                           epc,
    input  logic                                  branch_flush,
    input  logic                                  sq_empty,
    input  logic                                  stores_pending,
    output inst_id_t                              issue_id,
    output gc_ctrl_t                              ctrl,
    output trap_info_t                            trap,
    output logic                                  exc_ack,
    output logic                                  mret,
    output logic                                  interrupt_taken
);

    logic [`PC_ID_W:0] inflight_count;
    inst_id_t          oldest_id;
    logic [31:0]       oldest_pc;
    logic              exc_pending;
    logic              exc_valid;
    logic              squash;

    // ID allocation and oldest entry
    inflight_tracker tracker (
        .clk, .rst, .issue_valid, .issue, .retire_valid, .squash,
        .issue_id, .oldest_id, .oldest_pc, .inflight_count
    );

    // Oldest-instruction exception match
    exception_select exc_sel (
        .exc, .oldest_id, .oldest_pc, .inflight_count,
        .exc_pending, .exc_valid, .trap
    );

    global_control gc (
        .clk, .rst, .issue_valid, .issue, .branch_flush,
        .exc_pending, .exc_valid, .interrupt_pending, .inflight_count,
        .sq_empty, .stores_pending, .trap_vector, .epc,
        .ctrl, .squash, .exc_ack, .mret, .interrupt_taken
    );

endmodule

`default_nettype wire

//--- include/pipeline_ctrl_consts.svh
/*
 * Pipeline control constants
 * Instruction ID sizing, exception source count, init clear length, reset PC
 */
`ifndef PIPELINE_CTRL_CONSTS_SVH
`define PIPELINE_CTRL_CONSTS_SVH

// Instruction ID width, eight IDs in flight
`define PC_ID_W 3

// Units able to report an exception
`define PC_NUM_EXC_SOURCES 3

// Cycles of init_clear after reset
`define PC_INIT_CLEAR_DEPTH 16

// PC driven during the init clear
`define PC_RESET_VECTOR 32'h8000_0000

`endif

//--- pipeline_ctrl_top.f
+incdir+include
hw/pipeline_ctrl_pkg.sv
hw/inflight_tracker.sv
hw/exception_select.sv
hw/global_control.sv
hw/pipeline_ctrl_top.sv
verification/pipeline_ctrl_tb.sv

//--- verification/pipeline_ctrl_tb.sv
/*
 * Pipeline control testbench
 * Directed tests for init clear, FENCE.I, MRET, oldest exception and interrupts
 */
`timescale 1ns/10ps
`default_nettype none

`include "pipeline_ctrl_consts.svh"

module pipeline_ctrl_tb
    import pipeline_ctrl_pkg::*;
();

    // Five tests, each well inside its cycle budget
    localparam int TEST_BUDGET     = 800;
    localparam int WATCHDOG_CYCLES = 5 * TEST_BUDGET;
    localparam gc_ctrl_t REDIRECT_CARE =
        '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 32'hffff_ffff};

    logic        clk;
    logic        rst;
    logic        issue_valid;
    issue_t      issue;
    logic        retire_valid;
    exc_report_t [`PC_NUM_EXC_SOURCES-1:0] exc;
    logic        interrupt_pending;
    logic [31:0] trap_vector;
    logic [31:0] epc;
    logic        branch_flush;
    logic        sq_empty;
    logic        stores_pending;
    inst_id_t    issue_id;
    gc_ctrl_t    ctrl;
    trap_info_t  trap;
    logic        exc_ack;
    logic        mret;
    logic        interrupt_taken;

    // Expected ID allocation
    inst_id_t    next_id;
    int          in_flight;
    logic [31:0] pc_of_id [2**`PC_ID_W];

    // Seen during a redirect window
    int          override_cycles;
    gc_ctrl_t    override_ctrl;
    int          sq_flush_pulses;
    int          mret_pulses;
    int          irq_pulses;
    int          ack_pulses;
    trap_info_t  ack_trap;

    int          seed = 32'hdb850657;
    int          errors;
    int          tests_run;
    int          test_start_errors;

    pipeline_ctrl_top uut (
        .clk, .rst, .issue_valid, .issue, .retire_valid, .exc, .interrupt_pending,
        .trap_vector, .epc, .branch_flush, .sq_empty, .stores_pending,
        .issue_id, .ctrl, .trap, .exc_ack, .mret, .interrupt_taken
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_ctrl(string ctx, gc_ctrl_t got, gc_ctrl_t exp, gc_ctrl_t care);
        if ((got & care) !== (exp & care)) begin
            $display("Mismatch ctrl (%s): got %h expected %h care %h", ctx, got, exp, care);
            errors++;
        end
    endtask

    task automatic check_trap(string ctx, trap_info_t got, trap_info_t exp);
        if (got !== exp) begin
            $display("Mismatch trap (%s): got pc %h code %h tval %h expected %h %h %h",
                     ctx, got.pc, got.code, got.tval, exp.pc, exp.code, exp.tval);
            errors++;
        end
    endtask

    task automatic check_strobe(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(string name, inst_id_t got, inst_id_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(string what);
        $display("Error: %s", what);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus, every task starts and ends 5 ns after a rising edge

    function automatic gc_ctrl_t redirect_to(logic [31:0] target);
        return '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, target};
    endfunction

    function automatic logic [31:0] random_pc();
        return $random(seed) & 32'hffff_fffc;
    endfunction

    task automatic issue_normal(logic [31:0] pc);
        issue_valid = 1'b1;
        issue       = '{OP_NORMAL, pc};
        @(negedge clk);
        // ID shows up in the issue cycle itself
        check_id("issue_id", issue_id, next_id);
        pc_of_id[next_id] = pc;
        next_id++;
        in_flight++;
        @(posedge clk);
        #5;
        issue_valid = 1'b0;
    endtask

    task automatic issue_ops(int n);
        for (int i = 0; i < n; i++)
            issue_normal(random_pc());
    endtask

    task automatic issue_op(ctrl_op_t op, logic [31:0] pc);
        issue_valid = 1'b1;
        issue       = '{op, pc};
        @(posedge clk);
        #5;
        issue_valid = 1'b0;
    endtask

    // Oldest first, one per cycle
    task automatic retire_all(logic draining);
        while (in_flight > 0) begin
            retire_valid = 1'b1;
            @(negedge clk);
            if (draining) begin
                check_strobe("ctrl.fetch_hold", ctrl.fetch_hold, 1'b1);
                check_strobe("ctrl.pc_override", ctrl.pc_override, 1'b0);
                check_strobe("mret", mret, 1'b0);
                check_strobe("interrupt_taken", interrupt_taken, 1'b0);
            end
            @(posedge clk);
            #5;
            retire_valid = 1'b0;
            in_flight--;
        end
    endtask

    // Strobe, flush, discard and back to idle
    task automatic run_redirect(int cycles);
        logic acked;
        logic took;
        override_cycles = 0;
        override_ctrl   = '0;
        sq_flush_pulses = 0;
        mret_pulses     = 0;
        irq_pulses      = 0;
        ack_pulses      = 0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (ctrl.pc_override) begin
                if (override_cycles == 0)
                    override_ctrl = ctrl;
                override_cycles++;
            end
            if (ctrl.sq_flush) sq_flush_pulses++;
            if (mret) mret_pulses++;
            if (interrupt_taken) irq_pulses++;
            if (exc_ack) begin
                ack_pulses++;
                ack_trap = trap;
            end
            acked = exc_ack;
            took  = exc_ack | interrupt_taken;
            @(posedge clk);
            #5;
            // Sources hold a report until it is acknowledged
            if (acked) exc = '0;
            // Trap entry masks interrupts and drops all in-flight work
            if (took) begin
                interrupt_pending = 1'b0;
                in_flight         = 0;
            end
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_start_errors)
            $display("test %-12s ok", name);
        else
            $display("test %-12s %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic test_reset_clear();
        gc_ctrl_t clear_exp;
        gc_ctrl_t clear_care;
        gc_ctrl_t idle_care;
        int       clear_cycles;
        int       waited;
        logic     ended;
        // Holds, suppress, clear and override at the reset vector
        clear_exp  = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, `PC_RESET_VECTOR};
        clear_care = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 32'hffff_ffff};
        idle_care  = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 32'h0};
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        rst          = 1'b0;
        clear_cycles = 0;
        waited       = 0;
        ended        = 1'b0;
        while (!ended && waited < 4 * `PC_INIT_CLEAR_DEPTH) begin
            @(negedge clk);
            waited++;
            if (ctrl.init_clear) begin
                clear_cycles++;
                check_ctrl("init clear", ctrl, clear_exp, clear_care);
            end else if (clear_cycles > 0) begin
                ended = 1'b1;
            end
        end
        if (!ended)
            report_failure("init clear did not end");
        check_count("init_clear cycles", clear_cycles, `PC_INIT_CLEAR_DEPTH);
        check_ctrl("idle after clear", ctrl, '0, idle_care);
        @(posedge clk);
        #5;
        end_test("reset_clear");
    endtask

    task automatic test_fence_i();
        int          n;
        logic [31:0] op_pc;
        n     = 1 + int'($unsigned($random(seed)) % 5);
        op_pc = random_pc();
        issue_ops(n);
        issue_op(OP_IFENCE, op_pc);
        retire_all(1'b1);
        run_redirect(6);
        check_count("pc_override cycles", override_cycles, 1);
        // Redirect to the next instruction, fetch flushed with it
        check_ctrl("fence.i redirect", override_ctrl, redirect_to(op_pc + 32'd4),
                   REDIRECT_CARE);
        check_count("sq_flush cycles", sq_flush_pulses, 1);
        // Branch redirect alone
        branch_flush = 1'b1;
        @(negedge clk);
        check_strobe("ctrl.fetch_flush", ctrl.fetch_flush, 1'b1);
        check_strobe("ctrl.pc_override", ctrl.pc_override, 1'b0);
        @(posedge clk);
        #5;
        branch_flush = 1'b0;
        @(negedge clk);
        check_strobe("ctrl.fetch_flush", ctrl.fetch_flush, 1'b0);
        @(posedge clk);
        #5;
        end_test("fence_i");
    endtask

    task automatic test_mret();
        int n;
        n   = 1 + int'($unsigned($random(seed)) % 4);
        epc = random_pc();
        issue_ops(n);
        issue_op(OP_MRET, random_pc());
        retire_all(1'b1);
        run_redirect(6);
        check_count("mret pulses", mret_pulses, 1);
        check_count("pc_override cycles", override_cycles, 1);
        check_ctrl("mret redirect", override_ctrl, redirect_to(epc), REDIRECT_CARE);
        end_test("mret");
    endtask

    task automatic test_oldest_exception();
        inst_id_t    oldest;
        logic [3:0]  code_old;
        logic [31:0] tval_old;
        trap_info_t  exp_trap;
        issue_ops(3);
        oldest   = next_id - inst_id_t'(in_flight);
        code_old = 4'($random(seed));
        tval_old = $random(seed);
        // Younger report on the lower source index
        exc[0]   = '{1'b1, 4'($random(seed)), inst_id_t'(oldest + 1), 32'($random(seed))};
        exc[1]   = '{1'b1, code_old, oldest, tval_old};
        exp_trap = '{pc_of_id[oldest], code_old, tval_old};
        run_redirect(6);
        check_count("exc_ack pulses", ack_pulses, 1);
        check_trap("oldest exception", ack_trap, exp_trap);
        check_count("pc_override cycles", override_cycles, 1);
        check_ctrl("exception redirect", override_ctrl, redirect_to(trap_vector),
                   REDIRECT_CARE);
        // IDs continue from the next free one
        issue_normal(random_pc());
        retire_all(1'b0);
        end_test("oldest_exc");
    endtask

    task automatic test_interrupt();
        issue_ops(1 + int'($unsigned($random(seed)) % 4));
        interrupt_pending = 1'b1;
        @(posedge clk);
        #5;
        retire_all(1'b1);
        run_redirect(6);
        check_count("interrupt_taken pulses", irq_pulses, 1);
        check_count("exc_ack pulses", ack_pulses, 0);
        check_ctrl("interrupt redirect", override_ctrl, redirect_to(trap_vector),
                   REDIRECT_CARE);
        // Exception on the oldest op beats the interrupt
        issue_normal(random_pc());
        interrupt_pending = 1'b1;
        exc[2] = '{1'b1, 4'($random(seed)), inst_id_t'(next_id - 1), 32'($random(seed))};
        run_redirect(6);
        check_count("exc_ack pulses", ack_pulses, 1);
        check_count("interrupt_taken pulses", irq_pulses, 0);
        check_ctrl("trap redirect", override_ctrl, redirect_to(trap_vector), REDIRECT_CARE);
        end_test("interrupt");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        rst               = 1'b1;
        issue_valid       = 1'b0;
        issue             = '0;
        retire_valid      = 1'b0;
        exc               = '0;
        interrupt_pending = 1'b0;
        trap_vector       = 32'h8000_0100;
        epc               = '0;
        branch_flush      = 1'b0;
        sq_empty          = 1'b1;
        stores_pending    = 1'b0;
        next_id           = '0;
        in_flight         = 0;
        errors            = 0;
        tests_run         = 0;
        test_start_errors = 0;
        test_reset_clear();
        test_fence_i();
        test_mret();
        test_oldest_exception();
        test_interrupt();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
